//--- Makefile
# Verilator build and run for the LSPC CPU port testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tbLspcCpuPort -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+hw
hw/lspc_pkg.sv
hw/cpu_reg_decode.sv
hw/vram_access_exec.sv
hw/cpu_read_result.sv
hw/lspc_cpu_port.sv
testbench/vram_model.sv
testbench/tb_lspc_cpu_port.sv

//--- hw/cpu_read_result.sv
// CPU read result
// Keeps the mode register and registers the readback word
// selected by the finished operation
`include "lspc_config.svh"

module cpuReadResult (
	input logic clk,
	input logic rstN,
	input logic opValid,
	input lspc_pkg::opKind_t opKind,
	input lspc_pkg::dataWord opData,
	input logic opDone,
	input lspc_pkg::opKind_t doneKind,
	input lspc_pkg::dataWord readWord,
	input lspc_pkg::dataWord modValue,
	output lspc_pkg::dataWord cpuRdata
);
	import lspc_pkg::*;

	dataWord modeReg;
	dataWord srcWord;
	logic srcLoad;

	// Mode register, host storage only
	always_ff @(posedge clk) begin
		if (!rstN) begin
			modeReg <= '0;
		end else if (opValid && (opKind == opSetMode)) begin
			modeReg <= opData;
		end
	end

	// Readback source per finished op
	always_comb begin
		srcWord = readWord;
		srcLoad = 1'b0;
		case (doneKind)
			opVramRead: begin
				srcWord = readWord;
				srcLoad = 1'b1;
			end
			opReadMod: begin
				srcWord = modValue;
				srcLoad = 1'b1;
			end
			opReadMode: begin
				srcWord = modeReg;
				srcLoad = 1'b1;
			end
			// Writes keep the last read value
			default: srcLoad = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (opDone && srcLoad) begin
			cpuRdata <= srcWord;
		end
	end

endmodule

//--- hw/cpu_reg_decode.sv
// CPU register decode
// Runs the four-phase req/ack handshake with the host and turns
// each accepted access into one operation pulse for the datapath
`include "lspc_config.svh"

module cpuRegDecode (
	input logic clk,
	input logic rstN,
	input logic cpuReq,
	input logic cpuWe,
	input lspc_pkg::regIdx_t cpuIdx,
	input lspc_pkg::dataWord cpuWdata,
	input logic opDone,
	output logic cpuAck,
	output logic opValid,
	output lspc_pkg::opKind_t opKind,
	output lspc_pkg::dataWord opData
);
	import lspc_pkg::*;

	hsState_t state;
	opKind_t reqKind;
	logic accept;

	// New access only from idle, ack is low there
	assign accept = (state == hsIdle) && cpuReq;

	// Direction and index to operation
	always_comb begin
		reqKind = opReadMode;
		if (cpuWe) begin
			case (cpuIdx)
				`LSPC_REG_VRAMADDR: reqKind = opSetAddr;
				`LSPC_REG_VRAMRW: reqKind = opVramWrite;
				`LSPC_REG_VRAMMOD: reqKind = opSetMod;
				default: reqKind = opSetMode;
			endcase
		end else begin
			case (cpuIdx)
				// Both address and data reads fetch VRAM
				`LSPC_REG_VRAMADDR, `LSPC_REG_VRAMRW: reqKind = opVramRead;
				`LSPC_REG_VRAMMOD: reqKind = opReadMod;
				default: reqKind = opReadMode;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= hsIdle;
			cpuAck <= 1'b0;
			opValid <= 1'b0;
			opKind <= opSetAddr;
		end else begin
			// Single-cycle strobe
			opValid <= 1'b0;
			case (state)
				hsIdle: begin
					if (accept) begin
						opValid <= 1'b1;
						opKind <= reqKind;
						state <= hsBusy;
					end
				end
				// Wait for the datapath to finish
				hsBusy: begin
					if (opDone) begin
						cpuAck <= 1'b1;
						state <= hsAck;
					end
				end
				// Host holds req as back-pressure
				hsAck: begin
					if (!cpuReq) begin
						cpuAck <= 1'b0;
						state <= hsIdle;
					end
				end
				default: state <= hsIdle;
			endcase
		end
	end

	// Write data captured with the request
	always_ff @(posedge clk) begin
		if (accept) begin
			opData <= cpuWdata;
		end
	end

	// Ack holds for as long as the host keeps req up
	ackHold: assert property (@(posedge clk) disable iff (!rstN)
		cpuAck && cpuReq |=> cpuAck);

	// Operations start only from an idle handshake
	validFromIdle: assert property (@(posedge clk) disable iff (!rstN)
		opValid |-> $past(state == hsIdle) && !cpuAck);

endmodule

//--- hw/lspc_config.svh
// LSPC CPU port configuration
// Word and address widths plus the host register map
`ifndef LSPC_CONFIG_SVH
`define LSPC_CONFIG_SVH

// CPU bus and VRAM word width
`define LSPC_DATA_W 16

// VRAM word address, one single port
`define LSPC_VADDR_W 16

// Host selects one of four registers
`define LSPC_REGIDX_W 2

// Register map, word offsets
// Address register, sets the VRAM pointer
`define LSPC_REG_VRAMADDR 2'd0
// Data register, write stores and steps the pointer
`define LSPC_REG_VRAMRW 2'd1
// Modulo added after each data write
`define LSPC_REG_VRAMMOD 2'd2
// Mode register, plain storage
`define LSPC_REG_MODE 2'd3

`endif

//--- hw/lspc_cpu_port.sv
// LSPC CPU access port
// Host register interface to VRAM built from decode, execute
// and readback stages
`include "lspc_config.svh"

module lspcCpuPort (
	input logic clk,
	input logic rstN,
	// Host side
	input logic cpuReq,
	input logic cpuWe,
	input lspc_pkg::regIdx_t cpuIdx,
	input lspc_pkg::dataWord cpuWdata,
	output logic cpuAck,
	output lspc_pkg::dataWord cpuRdata,
	// VRAM side
	output lspc_pkg::vramAddr_t vramAddrOut,
	output lspc_pkg::dataWord vramWdata,
	output logic vramWe,
	output logic vramRe,
	input lspc_pkg::dataWord vramRdata
);
	import lspc_pkg::*;

	// Decode to execute and result
	logic opValid;
	opKind_t opKind;
	dataWord opData;
	// Execute back to decode and result
	logic opDone;
	opKind_t doneKind;
	dataWord readWord;
	dataWord modValue;

	cpuRegDecode uDecode (.clk(clk), .rstN(rstN), .cpuReq(cpuReq), .cpuWe(cpuWe),
		.cpuIdx(cpuIdx), .cpuWdata(cpuWdata), .opDone(opDone), .cpuAck(cpuAck),
		.opValid(opValid), .opKind(opKind), .opData(opData));

	vramAccessExec uExec (.clk(clk), .rstN(rstN), .opValid(opValid), .opKind(opKind),
		.opData(opData), .vramRdata(vramRdata), .opDone(opDone), .doneKind(doneKind),
		.readWord(readWord), .modValue(modValue), .vramAddrOut(vramAddrOut),
		.vramWdata(vramWdata), .vramWe(vramWe), .vramRe(vramRe));

	cpuReadResult uResult (.clk(clk), .rstN(rstN), .opValid(opValid), .opKind(opKind),
		.opData(opData), .opDone(opDone), .doneKind(doneKind), .readWord(readWord),
		.modValue(modValue), .cpuRdata(cpuRdata));

endmodule

//--- hw/lspc_pkg.sv
// LSPC CPU port types
// Width typedefs, operation codes and handshake states
`include "lspc_config.svh"

package lspc_pkg;

	// Widths with a meaning
	typedef logic [`LSPC_DATA_W-1:0] dataWord;
	typedef logic [`LSPC_VADDR_W-1:0] vramAddr_t;
	typedef logic [`LSPC_REGIDX_W-1:0] regIdx_t;

	// Operations passed from decode to execute and result
	typedef enum logic [2:0] {
		opSetAddr,
		opSetMod,
		opSetMode,
		opVramWrite,
		opVramRead,
		opReadMod,
		opReadMode
	} opKind_t;

	// Four-phase handshake FSM
	typedef enum logic [1:0] {
		hsIdle,
		hsBusy,
		hsAck
	} hsState_t;

endpackage

//--- hw/vram_access_exec.sv
// VRAM access execute stage
// Holds the VRAM pointer and modulo, issues VRAM writes with
// pointer auto-increment and VRAM reads with one-cycle latency
`include "lspc_config.svh"

module vramAccessExec (
	input logic clk,
	input logic rstN,
	input logic opValid,
	input lspc_pkg::opKind_t opKind,
	input lspc_pkg::dataWord opData,
	input lspc_pkg::dataWord vramRdata,
	output logic opDone,
	output lspc_pkg::opKind_t doneKind,
	output lspc_pkg::dataWord readWord,
	output lspc_pkg::dataWord modValue,
	output lspc_pkg::vramAddr_t vramAddrOut,
	output lspc_pkg::dataWord vramWdata,
	output logic vramWe,
	output logic vramRe
);
	import lspc_pkg::*;

	vramAddr_t addrReg;
	dataWord modReg;
	vramAddr_t nextAddr;

	// Pointer plus modulo, wraps at 16 bits
	assign nextAddr = addrReg + vramAddr_t'(modReg);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			addrReg <= '0;
			modReg <= '0;
			vramWe <= 1'b0;
			vramRe <= 1'b0;
			opDone <= 1'b0;
			doneKind <= opSetAddr;
		end else begin
			vramWe <= 1'b0;
			vramRe <= 1'b0;
			// Read completes when the data comes back
			opDone <= vramRe;
			// Step after the write cycle
			if (vramWe) begin
				addrReg <= nextAddr;
			end
			if (opValid) begin
				doneKind <= opKind;
				case (opKind)
					opSetAddr: begin
						addrReg <= vramAddr_t'(opData);
						opDone <= 1'b1;
					end
					opSetMod: begin
						modReg <= opData;
						opDone <= 1'b1;
					end
					// Strobe and done in the same cycle
					opVramWrite: begin
						vramWe <= 1'b1;
						opDone <= 1'b1;
					end
					// Done comes a cycle later
					opVramRead: begin
						vramRe <= 1'b1;
					end
					// Mode and readback need nothing here
					default: begin
						opDone <= 1'b1;
					end
				endcase
			end
		end
	end

	// Write word follows the strobe
	always_ff @(posedge clk) begin
		if (opValid && (opKind == opVramWrite)) begin
			vramWdata <= opData;
		end
	end

	// Pointer goes straight to the memory
	assign vramAddrOut = addrReg;
	// Memory data returns on readWord
	assign readWord = vramRdata;
	assign modValue = modReg;

	// One VRAM port, one direction per cycle
	noWeRe: assert property (@(posedge clk) disable iff (!rstN)
		!(vramWe && vramRe));

endmodule

//--- testbench/tb_lspc_cpu_port.sv
// Testbench for the LSPC CPU access port
// Runs host accesses over the four-phase handshake and checks readback
// against a reference model of pointer, modulo, mode and VRAM contents
`include "lspc_config.svh"

module tbLspcCpuPort;
	timeunit 1ns;
	timeprecision 1ps;
	import lspc_pkg::*;

	localparam int WAIT_LIMIT = 50;

	logic clk, rstN, cpuReq, cpuWe, cpuAck, vramWe, vramRe;
	regIdx_t cpuIdx;
	dataWord cpuWdata, cpuRdata, vramWdata, vramRdata;
	vramAddr_t vramAddrOut;

	// Checker state
	logic seenReq, expectRead;
	dataWord expRdata;
	vramAddr_t expVramAddr;
	dataWord expWdata;
	int errCount, errMark, testCount;

	// Reference model
	vramAddr_t refAddr;
	dataWord refMod, refMode;
	dataWord refMem [vramAddr_t];

	lspcCpuPort dut (.clk(clk), .rstN(rstN), .cpuReq(cpuReq), .cpuWe(cpuWe),
		.cpuIdx(cpuIdx), .cpuWdata(cpuWdata), .cpuAck(cpuAck), .cpuRdata(cpuRdata),
		.vramAddrOut(vramAddrOut), .vramWdata(vramWdata), .vramWe(vramWe),
		.vramRe(vramRe), .vramRdata(vramRdata));

	vramModel uVram (.clk(clk), .addr(vramAddrOut), .wdata(vramWdata), .we(vramWe),
		.re(vramRe), .rdata(vramRdata));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Read data is valid on the edge where ack rises
	rdataCheck: assert property (@(posedge clk) disable iff (!rstN)
		$rose(cpuAck) && expectRead |-> cpuRdata == expRdata)
		else begin
			errCount++;
			$display("ERR cpuRdata got %h expected %h", $sampled(cpuRdata), $sampled(expRdata));
		end

	// Every VRAM strobe uses the pointer the model expects
	addrCheck: assert property (@(posedge clk) disable iff (!rstN)
		(vramWe || vramRe) |-> vramAddrOut == expVramAddr)
		else begin
			errCount++;
			$display("ERR vramAddrOut got %h expected %h", $sampled(vramAddrOut),
				$sampled(expVramAddr));
		end

	// Written word is the one the host sent
	wdataCheck: assert property (@(posedge clk) disable iff (!rstN)
		vramWe |-> vramWdata == expWdata)
		else begin
			errCount++;
			$display("ERR vramWdata got %h expected %h", $sampled(vramWdata),
				$sampled(expWdata));
		end

	// Quiet port until the host asks for something
	idleAfterReset: assert property (@(posedge clk) disable iff (!rstN)
		!seenReq |-> !cpuAck && !vramWe && !vramRe)
		else begin
			errCount++;
			$display("cpuAck or a VRAM strobe went high before the first request");
		end

	// Back-pressure keeps ack up
	ackHeld: assert property (@(posedge clk) disable iff (!rstN)
		cpuAck && cpuReq |=> cpuAck)
		else begin
			errCount++;
			$display("cpuAck dropped while cpuReq was still high");
		end

	// Req must have been up on the edge that raised ack
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(cpuAck) |-> $past(cpuReq))
		else begin
			errCount++;
			$display("cpuAck rose while cpuReq was low");
		end

	// No VRAM traffic while a finished access is held
	noStrobeInAck: assert property (@(posedge clk) disable iff (!rstN)
		cpuAck |-> !vramWe && !vramRe)
		else begin
			errCount++;
			$display("VRAM strobe seen while cpuAck was high");
		end

	task automatic giveUp(input string what);
		$display("timeout waiting for %s", what);
		$display("TEST FAIL");
		$finish;
	endtask

	// One full req/ack exchange, req held for extra cycles after ack
	task automatic hostAccess(input logic we, input regIdx_t idx, input dataWord wdata,
		input int hold);
		int n;
		@(negedge clk);
		cpuWe = we;
		cpuIdx = idx;
		cpuWdata = wdata;
		cpuReq = 1'b1;
		seenReq = 1'b1;
		n = 0;
		while (!cpuAck) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) giveUp("cpuAck to rise");
		end
		repeat (hold) @(negedge clk);
		cpuReq = 1'b0;
		n = 0;
		while (cpuAck) begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) giveUp("cpuAck to fall");
		end
	endtask

	task automatic setAddr(input vramAddr_t a);
		refAddr = a;
		hostAccess(1'b1, `LSPC_REG_VRAMADDR, a, 0);
	endtask

	task automatic setMod(input dataWord m);
		refMod = m;
		hostAccess(1'b1, `LSPC_REG_VRAMMOD, m, 0);
	endtask

	task automatic setMode(input dataWord m);
		refMode = m;
		hostAccess(1'b1, `LSPC_REG_MODE, m, 0);
	endtask

	// Store at the pointer, then step by the modulo with 16-bit wrap
	task automatic writeData(input dataWord d, input int hold);
		expVramAddr = refAddr;
		expWdata = d;
		refMem[refAddr] = d;
		refAddr = refAddr + refMod;
		hostAccess(1'b1, `LSPC_REG_VRAMRW, d, hold);
	endtask

	task automatic readCheck(input regIdx_t idx, input dataWord exp, input int hold);
		expRdata = exp;
		expVramAddr = refAddr;
		expectRead = 1'b1;
		hostAccess(1'b0, idx, '0, hold);
		expectRead = 1'b0;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("%-28s %s", name, (errCount == errMark) ? "ok" : "failed");
		errMark = errCount;
	endtask

	initial begin
		vramAddr_t start, a;
		dataWord step;
		dataWord words [6];
		void'($urandom(32'hbdf7c928));
		cpuReq = 1'b0;
		cpuWe = 1'b0;
		cpuIdx = '0;
		cpuWdata = '0;
		rstN = 1'b0;
		seenReq = 1'b0;
		expectRead = 1'b0;
		expRdata = '0;
		expVramAddr = '0;
		expWdata = '0;
		errCount = 0;
		errMark = 0;
		testCount = 0;
		refAddr = '0;
		refMod = '0;
		refMode = '0;
		repeat (4) @(negedge clk);
		rstN = 1'b1;

		// Port stays idle with no request
		repeat (5) @(negedge clk);
		finishTest("reset idle");

		setAddr(16'h1234);
		writeData(16'hbeef, 0);
		setAddr(16'h1234);
		readCheck(`LSPC_REG_VRAMADDR, 16'hbeef, 0);
		finishTest("write then read");

		// Odd modulo keeps the six targets distinct across the wrap
		start = 16'hfff0 | vramAddr_t'($urandom_range(0, 15));
		step = dataWord'($urandom) | 16'h0001;
		setMod(step);
		setAddr(start);
		for (int k = 0; k < 6; k++) begin
			words[k] = dataWord'($urandom);
			writeData(words[k], 0);
		end
		a = start;
		for (int k = 0; k < 6; k++) begin
			setAddr(a);
			readCheck(`LSPC_REG_VRAMRW, words[k], 0);
			a = a + step;
		end
		finishTest("modulo step with wrap");

		setAddr(start);
		readCheck(`LSPC_REG_VRAMRW, refMem[start], 0);
		readCheck(`LSPC_REG_VRAMRW, refMem[start], 0);
		finishTest("read keeps address");

		setMod(dataWord'($urandom));
		setMode(dataWord'($urandom));
		writeData(dataWord'($urandom), 0);
		readCheck(`LSPC_REG_VRAMMOD, refMod, 0);
		readCheck(`LSPC_REG_MODE, refMode, 0);
		finishTest("modulo and mode readback");

		// Host stretches req after ack
		setAddr(16'h0040);
		writeData(16'hc0de, $urandom_range(1, 6));
		setAddr(16'h0040);
		readCheck(`LSPC_REG_VRAMADDR, 16'hc0de, $urandom_range(1, 6));
		finishTest("req held after ack");

		$display("tests %0d, failed checks %0d", testCount, errCount);
		if (errCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/vram_model.sv
// Behavioral VRAM for the testbench
// Single port, writes land on the clock, read data returns one clock later
module vramModel (
	input logic clk,
	input lspc_pkg::vramAddr_t addr,
	input lspc_pkg::dataWord wdata,
	input logic we,
	input logic re,
	output lspc_pkg::dataWord rdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import lspc_pkg::*;

	// Sparse storage, only written words exist
	dataWord mem [vramAddr_t];

	initial begin
		rdata = '0;
	end

	always @(posedge clk) begin
		if (we) begin
			mem[addr] = wdata;
		end
		if (re) begin
			// Unwritten words read as a pattern of the full address
			rdata <= mem.exists(addr) ? mem[addr] : (addr ^ 16'h5a3c);
		end
	end

endmodule
